/* verilog.f */
hw/mcast_xbar_pkg.sv
hw/mcast_addr_decode.sv
hw/mcast_demux.sv
hw/mcast_mux.sv
hw/mcast_xbar.sv
verification/mcast_xbar_properties.sv
verification/tb_mcast_xbar.sv

/* verification/tb_mcast_xbar.sv */
module tb_mcast_xbar;

  localparam int unsigned NS       = mcast_xbar_pkg::NUM_SLV_PORTS;
  localparam int unsigned NM       = mcast_xbar_pkg::NUM_MST_PORTS;
  // Random writes per slave port in the contention test
  localparam int unsigned NUM_RAND = 12;
  localparam int unsigned NUM_TXN  = 2 * NM + 3 + NS * NUM_RAND;
  localparam int unsigned TIMEOUT_CYCLES = NUM_TXN * 40 + 3;

  // Expected target set and joined response of one write
  typedef struct packed {
    mcast_xbar_pkg::mst_sel_t sel;
    mcast_xbar_pkg::resp_e    resp;
  } expect_t;

  logic                                   clk_i;
  logic                                   rst_n_i;
  logic [NS-1:0]                          slv_req_valid_i;
  logic [NS-1:0]                          slv_req_ready_o;
  mcast_xbar_pkg::wr_req_t [NS-1:0]       slv_req_i;
  logic [NS-1:0]                          slv_b_valid_o;
  mcast_xbar_pkg::resp_e [NS-1:0]         slv_b_resp_o;
  logic [NS-1:0]                          slv_b_ready_i;
  logic [NM-1:0]                          mst_req_valid_o;
  mcast_xbar_pkg::wr_req_t [NM-1:0]       mst_req_o;
  logic [NM-1:0]                          mst_req_ready_i;
  logic [NM-1:0]                          mst_b_valid_i;
  mcast_xbar_pkg::resp_e [NM-1:0]         mst_b_resp_i;
  logic [NM-1:0]                          mst_b_ready_o;

  logic [31:0] lfsr_q = 32'h9538_528b;
  // Scoreboard
  mcast_xbar_pkg::wr_req_t exp_arr_q [NM][$];
  mcast_xbar_pkg::resp_e   exp_resp_q [NS][$];
  mcast_xbar_pkg::wr_req_t rnd_req [NS][NUM_RAND];
  int unsigned outstanding = 0;
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned n_tests = 0;
  int unsigned test_err0;
  int unsigned test_chk0;
  string       test_name = "reset";
  // Target model state
  logic        busy [NM];
  logic [1:0]  wait_cnt [NM];

  mcast_xbar DUT (.*);

  always #4 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
    lfsr_q = {lfsr_q[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_step()};
    end
    return v;
  endfunction

  // A region is hit when the address and the base agree on every fixed bit
  function automatic expect_t ref_expect(input mcast_xbar_pkg::wr_req_t w);
    expect_t               e;
    mcast_xbar_pkg::addr_t free;
    e.sel = '0;
    for (int unsigned j = 0; j < NM; j++) begin
      free = mcast_xbar_pkg::ADDR_MAP[j].mask | w.mcast;
      if ((w.addr | free) == (mcast_xbar_pkg::ADDR_MAP[j].addr | free)) begin
        e.sel[j] = 1'b1;
      end
    end
    // Every target sees the same data, so one SLVERR makes the whole join SLVERR
    if (e.sel == '0) begin
      e.resp = mcast_xbar_pkg::RESP_DECERR;
    end else if (w.data[7:0] == 8'hee) begin
      e.resp = mcast_xbar_pkg::RESP_SLVERR;
    end else begin
      e.resp = mcast_xbar_pkg::RESP_OKAY;
    end
    return e;
  endfunction

  function automatic mcast_xbar_pkg::wr_req_t make_write(input logic [31:0] addr,
                                                          input logic [31:0] mcast,
                                                          input logic [31:0] data);
    mcast_xbar_pkg::wr_req_t w;
    w.addr  = addr;
    w.mcast = mcast;
    w.data  = data;
    return w;
  endfunction

  // Mostly unicast, some multicast, some unmapped
  function automatic mcast_xbar_pkg::wr_req_t random_write(input int unsigned s,
                                                            input int unsigned i);
    mcast_xbar_pkg::wr_req_t w;
    logic [31:0] kind;
    logic [31:0] loc;
    logic [31:0] pick;
    logic [31:0] noise;
    logic [31:0] err_pick;
    kind     = rand_bits(3);
    loc      = rand_bits(14);
    pick     = rand_bits(2);
    noise    = rand_bits(16);
    err_pick = rand_bits(2);
    w.addr  = {18'h0, loc[13:2], 2'b00};
    w.mcast = '0;
    if (kind == 32'd5 || kind == 32'd6) begin
      w.mcast = (pick == 0) ? 32'h1000 : (pick == 1) ? 32'h2000 : 32'h3000;
    end
    if (kind == 32'd7) begin
      w.addr = w.addr | 32'h0000_8000;
    end
    w.data = {4'(s), 4'(i), noise[15:0], (err_pick == 0) ? 8'hee : 8'h3c};
    return w;
  endfunction

  task automatic send_write(input int unsigned s, input mcast_xbar_pkg::wr_req_t w);
    expect_t e;
    e = ref_expect(w);
    for (int unsigned m = 0; m < NM; m++) begin
      if (e.sel[m]) begin
        exp_arr_q[m].push_back(w);
      end
    end
    exp_resp_q[s].push_back(e.resp);
    outstanding++;
    slv_req_i[s]       = w;
    slv_req_valid_i[s] = 1'b1;
    do @(posedge clk_i); while (!slv_req_ready_o[s]);
    #1;
    slv_req_valid_i[s] = 1'b0;
  endtask

  task automatic check_arrival(input int unsigned m, input mcast_xbar_pkg::wr_req_t w);
    int hit;
    hit = -1;
    for (int k = 0; k < exp_arr_q[m].size(); k++) begin
      if (hit < 0 && exp_arr_q[m][k] == w) begin
        hit = k;
      end
    end
    n_checks++;
    assert (hit >= 0) else begin
      $display("In %s master port %0d received a write that was not expected: %h",
               test_name, m, w);
      n_errors++;
    end
    if (hit >= 0) begin
      exp_arr_q[m].delete(hit);
    end
  endtask

  task automatic check_response(input int unsigned s, input mcast_xbar_pkg::resp_e act);
    mcast_xbar_pkg::resp_e exp;
    n_checks++;
    assert (exp_resp_q[s].size() > 0) else begin
      $display("In %s slave port %0d got a response with no write outstanding",
               test_name, s);
      n_errors++;
    end
    if (exp_resp_q[s].size() > 0) begin
      exp = exp_resp_q[s].pop_front();
      outstanding--;
      assert (act == exp) else begin
        $display("FAIL %s: slave port %0d response expected %0d actual %0d",
                 test_name, s, exp, act);
        n_errors++;
      end
    end
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = n_errors;
    test_chk0 = n_checks;
  endtask

  // All responses back means all writes have left the master ports
  task automatic finish_test();
    do begin
      @(posedge clk_i);
      #1;
    end while (outstanding != 0);
    for (int unsigned m = 0; m < NM; m++) begin
      n_checks++;
      assert (exp_arr_q[m].size() == 0) else begin
        $display("In %s %0d writes never reached master port %0d",
                 test_name, exp_arr_q[m].size(), m);
        n_errors++;
        exp_arr_q[m].delete();
      end
    end
    n_tests++;
    $display("Test %s done: %0d checks, %0d errors", test_name,
             n_checks - test_chk0, n_errors - test_err0);
  endtask

  // Handshakes are sampled at the edge, inputs change 1 unit later
  always @(posedge clk_i) begin : compare
    if (rst_n_i) begin
      for (int unsigned m = 0; m < NM; m++) begin
        if (mst_req_valid_o[m] && mst_req_ready_i[m]) begin
          check_arrival(m, mst_req_o[m]);
        end
      end
      for (int unsigned s = 0; s < NS; s++) begin
        if (slv_b_valid_o[s] && slv_b_ready_i[s]) begin
          check_response(s, slv_b_resp_o[s]);
        end
      end
    end
  end

  // Four targets and the response back-pressure in one process
  // so the LFSR is stepped in a fixed order
  initial begin : target_model
    logic [NM-1:0] req_hs;
    logic [NM-1:0] b_hs;
    logic [NM-1:0] err_hit;
    for (int unsigned m = 0; m < NM; m++) begin
      busy[m]     = 1'b0;
      wait_cnt[m] = '0;
    end
    forever begin
      @(posedge clk_i);
      req_hs = mst_req_valid_o & mst_req_ready_i;
      b_hs   = mst_b_valid_i & mst_b_ready_o;
      for (int unsigned m = 0; m < NM; m++) begin
        err_hit[m] = (mst_req_o[m].data[7:0] == 8'hee);
      end
      #1;
      for (int unsigned m = 0; m < NM; m++) begin
        if (b_hs[m]) begin
          mst_b_valid_i[m] = 1'b0;
        end
        if (req_hs[m]) begin
          busy[m]     = 1'b1;
          wait_cnt[m] = 2'(rand_bits(2));
          mst_b_resp_i[m] = err_hit[m] ? mcast_xbar_pkg::RESP_SLVERR :
                                         mcast_xbar_pkg::RESP_OKAY;
        end else if (busy[m] && wait_cnt[m] != 0) begin
          wait_cnt[m] = wait_cnt[m] - 2'd1;
        end
        if (busy[m] && wait_cnt[m] == 0) begin
          mst_b_valid_i[m] = 1'b1;
          busy[m]          = 1'b0;
        end
        // One write per target, random stalls while free
        mst_req_ready_i[m] = (!busy[m] && !mst_b_valid_i[m]) ? lfsr_step() : 1'b0;
      end
      // Random stalls on the slave response channels
      for (int unsigned s = 0; s < NS; s++) begin
        slv_b_ready_i[s] = lfsr_step();
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Checks failed");
    $finish;
  end

  initial begin : main_seq
    clk_i           = 1'b0;
    rst_n_i         = 1'b0;
    slv_req_valid_i = '0;
    slv_req_i       = '0;
    slv_b_ready_i   = '1;
    mst_req_ready_i = '0;
    mst_b_valid_i   = '0;
    for (int unsigned m = 0; m < NM; m++) begin
      mst_b_resp_i[m] = mcast_xbar_pkg::RESP_OKAY;
    end
    // Contention stimulus drawn before the targets start using the LFSR
    for (int unsigned s = 0; s < NS; s++) begin
      for (int unsigned i = 0; i < NUM_RAND; i++) begin
        rnd_req[s][i] = random_write(s, i);
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    start_test("unicast");
    for (int unsigned s = 0; s < NS; s++) begin
      for (int unsigned j = 0; j < NM; j++) begin
        send_write(s, make_write((32'(j) << 12) | 32'(16 * (s + 1) + 4 * j), 32'h0,
                                 32'h5100_0000 | 32'(s << 8) | 32'(j)));
      end
    end
    finish_test();

    start_test("multicast");
    send_write(0, make_write(32'h0000_0000, 32'h0000_3000, 32'h1234_5678));
    finish_test();

    start_test("response join");
    send_write(1, make_write(32'h0000_0040, 32'h0000_3000, 32'hcafe_00ee));
    finish_test();

    start_test("decode error");
    send_write(0, make_write(32'h0000_8000, 32'h0, 32'hdead_0001));
    finish_test();

    start_test("contention");
    fork
      begin : port0_stream
        for (int unsigned i = 0; i < NUM_RAND; i++) begin
          send_write(0, rnd_req[0][i]);
        end
      end
      begin : port1_stream
        for (int unsigned i = 0; i < NUM_RAND; i++) begin
          send_write(1, rnd_req[1][i]);
        end
      end
    join
    finish_test();

    $display("%0d tests, %0d checks, %0d errors, %0d property failures",
             n_tests, n_checks, n_errors, DUT.i_props.fail_cnt);
    if (n_errors == 0 && DUT.i_props.fail_cnt == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* verification/mcast_xbar_properties.sv */
module mcast_xbar_properties (
  input logic                                                        clk_i,
  input logic                                                        rst_n_i,
  input logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                    slv_req_valid_i,
  input logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                    slv_req_ready_o,
  input mcast_xbar_pkg::wr_req_t [mcast_xbar_pkg::NUM_SLV_PORTS-1:0] slv_req_i,
  input logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                    slv_b_valid_o,
  input mcast_xbar_pkg::resp_e [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]   slv_b_resp_o,
  input logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                    slv_b_ready_i,
  input logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                    mst_req_valid_o,
  input mcast_xbar_pkg::wr_req_t [mcast_xbar_pkg::NUM_MST_PORTS-1:0] mst_req_o,
  input logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                    mst_req_ready_i
);

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  for (genvar s = 0; s < mcast_xbar_pkg::NUM_SLV_PORTS; s++) begin : gen_slv
    // Slave request held until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_req_valid_i[s] && !slv_req_ready_o[s] |=>
        slv_req_valid_i[s] && $stable(slv_req_i[s]))
    else begin
      $error("Slave port %0d request changed before ready", s);
      fail_cnt++;
    end

    // Slave response held until taken
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      slv_b_valid_o[s] && !slv_b_ready_i[s] |=>
        slv_b_valid_o[s] && $stable(slv_b_resp_o[s]))
    else begin
      $error("Slave port %0d response changed before ready", s);
      fail_cnt++;
    end
  end

  for (genvar m = 0; m < mcast_xbar_pkg::NUM_MST_PORTS; m++) begin : gen_mst
    // Output register keeps the write under back-pressure
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mst_req_valid_o[m] && !mst_req_ready_i[m] |=>
        mst_req_valid_o[m] && $stable(mst_req_o[m]))
    else begin
      $error("Master port %0d request changed before ready", m);
      fail_cnt++;
    end
  end

  // No master request right out of reset
  assert property (@(posedge clk_i) $rose(rst_n_i) |-> (mst_req_valid_o == '0))
  else begin
    $error("Master request valid high right after reset");
    fail_cnt++;
  end

endmodule

bind mcast_xbar mcast_xbar_properties i_props (.*);

/* hw/mcast_xbar.sv */
module mcast_xbar (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  // Slave ports
  input  logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_req_valid_i,
  output logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_req_ready_o,
  input  mcast_xbar_pkg::wr_req_t [mcast_xbar_pkg::NUM_SLV_PORTS-1:0] slv_req_i,
  output logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_b_valid_o,
  output mcast_xbar_pkg::resp_e [mcast_xbar_pkg::NUM_SLV_PORTS-1:0] slv_b_resp_o,
  input  logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_b_ready_i,
  // Master ports
  output logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                  mst_req_valid_o,
  output mcast_xbar_pkg::wr_req_t [mcast_xbar_pkg::NUM_MST_PORTS-1:0] mst_req_o,
  input  logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                  mst_req_ready_i,
  input  logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                  mst_b_valid_i,
  input  mcast_xbar_pkg::resp_e [mcast_xbar_pkg::NUM_MST_PORTS-1:0] mst_b_resp_i,
  output logic [mcast_xbar_pkg::NUM_MST_PORTS-1:0]                  mst_b_ready_o
);

  localparam int unsigned NS = mcast_xbar_pkg::NUM_SLV_PORTS;
  localparam int unsigned NM = mcast_xbar_pkg::NUM_MST_PORTS;

  // Demux side, indexed [slave][master]
  mcast_xbar_pkg::mst_sel_t [NS-1:0]                   dmx_valid;
  mcast_xbar_pkg::mst_sel_t [NS-1:0]                   dmx_grant;
  mcast_xbar_pkg::mst_sel_t [NS-1:0]                   dmx_b_valid;
  mcast_xbar_pkg::mst_sel_t [NS-1:0]                   dmx_b_ready;
  mcast_xbar_pkg::resp_e    [NS-1:0][NM-1:0]           dmx_b_resp;
  mcast_xbar_pkg::wr_req_t  [NS-1:0]                   dmx_req;
  logic                     [NS-1:0]                   dmx_commit;

  // Mux side, indexed [master][slave]
  logic                     [NM-1:0][NS-1:0]           mux_valid;
  logic                     [NM-1:0][NS-1:0]           mux_grant;
  logic                     [NM-1:0][NS-1:0]           mux_commit;
  logic                     [NM-1:0][NS-1:0]           mux_b_valid;
  logic                     [NM-1:0][NS-1:0]           mux_b_ready;
  mcast_xbar_pkg::resp_e    [NM-1:0]                   mux_b_resp;

  for (genvar s = 0; s < NS; s++) begin : gen_slv_demux
    mcast_demux i_demux (
      .clk_i,
      .rst_n_i,
      .slv_req_valid_i (slv_req_valid_i[s]),
      .slv_req_ready_o (slv_req_ready_o[s]),
      .slv_req_i       (slv_req_i[s]),
      .slv_b_valid_o   (slv_b_valid_o[s]),
      .slv_b_resp_o    (slv_b_resp_o[s]),
      .slv_b_ready_i   (slv_b_ready_i[s]),
      .mst_valid_o     (dmx_valid[s]),
      .mst_req_o       (dmx_req[s]),
      .mst_grant_i     (dmx_grant[s]),
      .commit_o        (dmx_commit[s]),
      .mst_b_valid_i   (dmx_b_valid[s]),
      .mst_b_resp_i    (dmx_b_resp[s]),
      .mst_b_ready_o   (dmx_b_ready[s])
    );
  end

  // Transpose between the two sides
  for (genvar s = 0; s < NS; s++) begin : gen_cross_slv
    for (genvar m = 0; m < NM; m++) begin : gen_cross_mst
      assign mux_valid[m][s]   = dmx_valid[s][m];
      assign dmx_grant[s][m]   = mux_grant[m][s];
      // Commit is shared by all targets of a demux
      assign mux_commit[m][s]  = dmx_commit[s];
      assign dmx_b_valid[s][m] = mux_b_valid[m][s];
      assign dmx_b_resp[s][m]  = mux_b_resp[m];
      assign mux_b_ready[m][s] = dmx_b_ready[s][m];
    end
  end

  for (genvar m = 0; m < NM; m++) begin : gen_mst_mux
    mcast_mux i_mux (
      .clk_i,
      .rst_n_i,
      .slv_valid_i     (mux_valid[m]),
      .slv_req_i       (dmx_req),
      .slv_commit_i    (mux_commit[m]),
      .grant_o         (mux_grant[m]),
      .slv_b_valid_o   (mux_b_valid[m]),
      .slv_b_resp_o    (mux_b_resp[m]),
      .slv_b_ready_i   (mux_b_ready[m]),
      .mst_req_valid_o (mst_req_valid_o[m]),
      .mst_req_o       (mst_req_o[m]),
      .mst_req_ready_i (mst_req_ready_i[m]),
      .mst_b_valid_i   (mst_b_valid_i[m]),
      .mst_b_resp_i    (mst_b_resp_i[m]),
      .mst_b_ready_o   (mst_b_ready_o[m])
    );
  end

endmodule

/* hw/mcast_mux.sv */
module mcast_mux (
  input  logic                                                      clk_i,
  input  logic                                                      rst_n_i,
  // Requests from the demuxes
  input  logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_valid_i,
  input  mcast_xbar_pkg::wr_req_t [mcast_xbar_pkg::NUM_SLV_PORTS-1:0] slv_req_i,
  input  logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_commit_i,
  output logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  grant_o,
  // Responses back to the demuxes
  output logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_b_valid_o,
  output mcast_xbar_pkg::resp_e                                     slv_b_resp_o,
  input  logic [mcast_xbar_pkg::NUM_SLV_PORTS-1:0]                  slv_b_ready_i,
  // Master port
  output logic                                                      mst_req_valid_o,
  output mcast_xbar_pkg::wr_req_t                                   mst_req_o,
  input  logic                                                      mst_req_ready_i,
  input  logic                                                      mst_b_valid_i,
  input  mcast_xbar_pkg::resp_e                                     mst_b_resp_i,
  output logic                                                      mst_b_ready_o
);

  mcast_xbar_pkg::mux_state_e state_q, state_d;
  // Output register and owner of the write
  mcast_xbar_pkg::wr_req_t    req_q;
  mcast_xbar_pkg::slv_idx_t   idx_q;
  mcast_xbar_pkg::slv_idx_t   win_idx;
  logic                       load;

  // Fixed priority, lowest slave port first, same order in every mux
  always_comb begin : grant_arb
    logic taken;
    taken   = 1'b0;
    grant_o = '0;
    if (state_q == mcast_xbar_pkg::MX_IDLE) begin
      for (int unsigned s = 0; s < mcast_xbar_pkg::NUM_SLV_PORTS; s++) begin
        if (slv_valid_i[s] && !taken) begin
          grant_o[s] = 1'b1;
          taken      = 1'b1;
        end
      end
    end
  end

  // Load only when the granted demux commits all its targets
  always_comb begin
    win_idx = '0;
    load    = 1'b0;
    for (int unsigned s = 0; s < mcast_xbar_pkg::NUM_SLV_PORTS; s++) begin
      if (grant_o[s] && slv_commit_i[s]) begin
        win_idx = mcast_xbar_pkg::slv_idx_t'(s);
        load    = 1'b1;
      end
    end
  end

  assign mst_req_valid_o = (state_q == mcast_xbar_pkg::MX_OUT);
  assign mst_req_o       = req_q;

  // Response passes straight through to the recorded port
  assign mst_b_ready_o = (state_q == mcast_xbar_pkg::MX_WAIT_B) && slv_b_ready_i[idx_q];
  assign slv_b_resp_o  = mst_b_resp_i;

  always_comb begin
    for (int unsigned s = 0; s < mcast_xbar_pkg::NUM_SLV_PORTS; s++) begin
      slv_b_valid_o[s] = (state_q == mcast_xbar_pkg::MX_WAIT_B) && mst_b_valid_i &&
                         (idx_q == mcast_xbar_pkg::slv_idx_t'(s));
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      mcast_xbar_pkg::MX_IDLE: begin
        if (load) begin
          state_d = mcast_xbar_pkg::MX_OUT;
        end
      end
      // Hold the payload until the target takes it
      mcast_xbar_pkg::MX_OUT: begin
        if (mst_req_ready_i) begin
          state_d = mcast_xbar_pkg::MX_WAIT_B;
        end
      end
      mcast_xbar_pkg::MX_WAIT_B: begin
        if (mst_b_valid_i && mst_b_ready_o) begin
          state_d = mcast_xbar_pkg::MX_IDLE;
        end
      end
      default: state_d = mcast_xbar_pkg::MX_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mcast_xbar_pkg::MX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Payload and owner index
  always_ff @(posedge clk_i) begin
    if (load) begin
      req_q <= slv_req_i[win_idx];
      idx_q <= win_idx;
    end
  end

endmodule

/* hw/mcast_demux.sv */
module mcast_demux (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  // Slave port request channel
  input  logic                     slv_req_valid_i,
  output logic                     slv_req_ready_o,
  input  mcast_xbar_pkg::wr_req_t  slv_req_i,
  // Slave port response channel
  output logic                     slv_b_valid_o,
  output mcast_xbar_pkg::resp_e    slv_b_resp_o,
  input  logic                     slv_b_ready_i,
  // Requests towards the muxes
  output mcast_xbar_pkg::mst_sel_t mst_valid_o,
  output mcast_xbar_pkg::wr_req_t  mst_req_o,
  input  mcast_xbar_pkg::mst_sel_t mst_grant_i,
  output logic                     commit_o,
  // Responses from the muxes
  input  mcast_xbar_pkg::mst_sel_t mst_b_valid_i,
  input  mcast_xbar_pkg::resp_e [mcast_xbar_pkg::NUM_MST_PORTS-1:0] mst_b_resp_i,
  output mcast_xbar_pkg::mst_sel_t mst_b_ready_o
);

  mcast_xbar_pkg::demux_state_e state_q, state_d;
  // Accepted write
  mcast_xbar_pkg::wr_req_t      req_q;
  // Decoded target set of the incoming request
  mcast_xbar_pkg::mst_sel_t     dec_sel;
  // Target set, bits drop as responses come back
  mcast_xbar_pkg::mst_sel_t     pend_q, pend_d;
  // Joined response so far
  mcast_xbar_pkg::resp_e        resp_q, resp_d;
  mcast_xbar_pkg::mst_sel_t     b_take;
  logic                         req_hs;
  logic                         all_grant;

  mcast_addr_decode i_addr_decode (
    .addr_i  (slv_req_i.addr),
    .mcast_i (slv_req_i.mcast),
    .sel_o   (dec_sel)
  );

  // Only one write in flight per slave port
  assign slv_req_ready_o = (state_q == mcast_xbar_pkg::ST_IDLE);
  assign req_hs          = slv_req_valid_i & slv_req_ready_o;

  // Ask every target at once
  assign mst_valid_o = (state_q == mcast_xbar_pkg::ST_ISSUE) ? pend_q : '0;
  assign mst_req_o   = req_q;

  // All-or-nothing commit, every target must grant in the same cycle
  assign all_grant = ((mst_grant_i & pend_q) == pend_q);
  assign commit_o  = (state_q == mcast_xbar_pkg::ST_ISSUE) && all_grant;

  // Accept responses from targets still outstanding
  assign mst_b_ready_o = (state_q == mcast_xbar_pkg::ST_WAIT_B) ? pend_q : '0;
  assign b_take        = mst_b_valid_i & mst_b_ready_o;

  assign slv_b_valid_o = (state_q == mcast_xbar_pkg::ST_RESP);
  assign slv_b_resp_o  = resp_q;

  always_comb begin
    state_d = state_q;
    pend_d  = pend_q;
    resp_d  = resp_q;
    case (state_q)
      mcast_xbar_pkg::ST_IDLE: begin
        if (req_hs) begin
          pend_d = dec_sel;
          if (dec_sel == '0) begin
            // No region hit, answer directly
            resp_d  = mcast_xbar_pkg::RESP_DECERR;
            state_d = mcast_xbar_pkg::ST_RESP;
          end else begin
            resp_d  = mcast_xbar_pkg::RESP_OKAY;
            state_d = mcast_xbar_pkg::ST_ISSUE;
          end
        end
      end
      mcast_xbar_pkg::ST_ISSUE: begin
        if (all_grant) begin
          state_d = mcast_xbar_pkg::ST_WAIT_B;
        end
      end
      mcast_xbar_pkg::ST_WAIT_B: begin
        // Responses arrive in any order, keep the worst code
        for (int unsigned m = 0; m < mcast_xbar_pkg::NUM_MST_PORTS; m++) begin
          if (b_take[m]) begin
            pend_d[m] = 1'b0;
            if (mst_b_resp_i[m] > resp_d) begin
              resp_d = mst_b_resp_i[m];
            end
          end
        end
        if (pend_d == '0) begin
          state_d = mcast_xbar_pkg::ST_RESP;
        end
      end
      mcast_xbar_pkg::ST_RESP: begin
        if (slv_b_ready_i) begin
          state_d = mcast_xbar_pkg::ST_IDLE;
        end
      end
      default: state_d = mcast_xbar_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= mcast_xbar_pkg::ST_IDLE;
      pend_q  <= '0;
      resp_q  <= mcast_xbar_pkg::RESP_OKAY;
    end else begin
      state_q <= state_d;
      pend_q  <= pend_d;
      resp_q  <= resp_d;
    end
  end

  // Payload register
  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      req_q <= slv_req_i;
    end
  end

endmodule

/* hw/mcast_addr_decode.sv */
module mcast_addr_decode (
  // Request address
  input  mcast_xbar_pkg::addr_t    addr_i,
  // Address bits that may take any value
  input  mcast_xbar_pkg::addr_t    mcast_i,
  // Every master port whose region is hit
  output mcast_xbar_pkg::mst_sel_t sel_o
);

  // One comparator per rule
  for (genvar j = 0; j < mcast_xbar_pkg::NUM_MST_PORTS; j++) begin : gen_rule
    // Bits that must equal the rule base
    mcast_xbar_pkg::addr_t care;
    // Bits where address and base disagree
    mcast_xbar_pkg::addr_t diff;

    // Region bits and multicast bits are both don't-care
    assign care = ~(mcast_xbar_pkg::ADDR_MAP[j].mask | mcast_i);
    assign diff = addr_i ^ mcast_xbar_pkg::ADDR_MAP[j].addr;

    // Hit when no cared-for bit differs
    assign sel_o[j] = ((diff & care) == '0);
  end

  // A unicast has mcast_i at zero and hits one region at most
  // A multicast can hit several, an empty set means decode error

endmodule

/* hw/mcast_xbar_pkg.sv */
package mcast_xbar_pkg;

  // Port counts
  localparam int unsigned NUM_SLV_PORTS = 2;
  localparam int unsigned NUM_MST_PORTS = 4;

  // Payload widths
  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;

  // Set of master ports, one bit per port
  typedef logic [NUM_MST_PORTS-1:0] mst_sel_t;
  // Index of the slave port that owns a write
  typedef logic [$clog2(NUM_SLV_PORTS)-1:0] slv_idx_t;

  // Mask rule, mask bits are free inside the region
  typedef struct packed {
    addr_t addr;
    addr_t mask;
  } addr_rule_t;

  // Fixed address map, one 4 KiB region per master port
  localparam addr_rule_t ADDR_MAP [NUM_MST_PORTS] = '{
    '{addr: 32'h0000_0000, mask: 32'h0000_0fff},
    '{addr: 32'h0000_1000, mask: 32'h0000_0fff},
    '{addr: 32'h0000_2000, mask: 32'h0000_0fff},
    '{addr: 32'h0000_3000, mask: 32'h0000_0fff}
  };

  // Single-beat write request
  // mcast marks the address bits that may differ
  typedef struct packed {
    addr_t addr;
    addr_t mcast;
    data_t data;
  } wr_req_t;

  // Write response code, a larger value is worse
  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2,
    RESP_DECERR = 2'd3
  } resp_e;

  // Demux FSM
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ISSUE,
    ST_WAIT_B,
    ST_RESP
  } demux_state_e;

  // Mux FSM
  typedef enum logic [1:0] {
    MX_IDLE,
    MX_OUT,
    MX_WAIT_B
  } mux_state_e;

endpackage
